// File: vlog.f
+incdir+design
design/hps_proto_pkg.sv
design/hps_core_pkg.sv
design/hps_cmd_decode.sv
design/hps_core_regs.sv
design/file_loader.sv
design/hps_readback.sv
design/hps_link.sv
tests/hps_clock_gen.sv
tests/hps_link_props.sv
tests/tb_hps_link.sv

// File: Bender.yml
package:
  name: hps_link

sources:
  - include_dirs:
      - design
    files:
      - design/hps_proto_pkg.sv
      - design/hps_core_pkg.sv
      - design/hps_cmd_decode.sv
      - design/hps_core_regs.sv
      - design/file_loader.sv
      - design/hps_readback.sv
      - design/hps_link.sv
  - target: test
    files:
      - tests/hps_clock_gen.sv
      - tests/hps_link_props.sv
      - tests/tb_hps_link.sv

// File: tests/tb_hps_link.sv
// testbench for the host link: random frames, reference model, checker and report
`timescale 1ns/100ps

module tb_hps_link;

	// frames sent by all tests, 40 cycles budgeted for each
	localparam int N_FRAMES   = 10;
	localparam int TIMEOUT_NS = (N_FRAMES * 40 + 200) * 8;

	logic         clk_sys;
	logic         rst_n;
	logic         io_enable;
	logic         fp_enable;
	logic         io_strobe;
	logic [15:0]  io_din;
	logic [127:0] status_in;
	logic         status_set;
	logic [15:0]  io_dout;
	logic [1:0]   buttons;
	logic         forced_scandoubler;
	logic         direct_video;
	logic [31:0]  joystick_0;
	logic [31:0]  joystick_1;
	logic [127:0] status;
	logic         ioctl_download;
	logic [15:0]  ioctl_index;
	logic         ioctl_wr;
	logic [26:0]  ioctl_addr;
	logic [7:0]   ioctl_dout;

	// reference model state
	logic [15:0]  m_cfg;
	logic [31:0]  m_joy0;
	logic [31:0]  m_joy1;
	logic [127:0] m_status;
	logic [127:0] m_req;
	logic [3:0]   m_count;
	logic [34:0]  wr_expect[$];
	logic [34:0]  exp_wr;

	logic [31:0]  lfsr = 32'd5;
	int           checks = 0;
	int           errors = 0;
	int           tests = 0;
	int           failed = 0;
	int           wr_seen = 0;

	hps_clock_gen u_clk (.clk_sys, .rst_n);
	hps_link u_dut (.*);

	//////////////////////////////////////////////////
	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic compare_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp, act);
		end
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		if (errors != err0) begin
			failed++;
			$display("test %s: %0d errors", name, errors - err0);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// one-cycle strobe, then one idle cycle
	task automatic send_word(input logic [15:0] w);
		@(posedge clk_sys);
		#1;
		io_strobe = 1'b1;
		io_din    = w;
		@(posedge clk_sys);
		#1;
		io_strobe = 1'b0;
	endtask

	task automatic open_frame(input logic uio, input logic [7:0] cmd);
		@(posedge clk_sys);
		#1;
		io_enable = uio;
		fp_enable = !uio;
		send_word({8'h00, cmd});
	endtask

	// drop the enable and let the last word finish
	task automatic close_frame();
		@(posedge clk_sys);
		#1;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	// reply is read two cycles after the strobe
	task automatic read_reply(input logic [15:0] w, output logic [15:0] rd);
		send_word(w);
		@(posedge clk_sys);
		@(posedge clk_sys);
		@(negedge clk_sys);
		rd = io_dout;
	endtask

	task automatic pulse_status(input logic [127:0] v);
		@(posedge clk_sys);
		#1;
		status_in  = v;
		status_set = 1'b1;
		@(posedge clk_sys);
		#1;
		status_set = 1'b0;
		m_req   = v;
		m_count = m_count + 1'b1;
	endtask

	//////////////////////////////////////////////////
	// every ioctl_wr pulse against the model's byte and address
	always @(negedge clk_sys) begin
		if (rst_n && ioctl_wr) begin
			wr_seen++;
			if (wr_expect.size() == 0) begin
				errors++;
				$display("ioctl_wr pulsed at %0t ns with no byte outstanding", $time);
			end else begin
				exp_wr = wr_expect.pop_front();
				compare_value("ioctl_addr", exp_wr[34:8], ioctl_addr);
				compare_value("ioctl_dout", exp_wr[7:0], ioctl_dout);
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAIL");
		$finish;
	end

	//////////////////////////////////////////////////
	initial begin
		int          err0;
		int          n;
		int          wr0;
		logic [15:0] w;
		logic [15:0] rd;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		m_cfg      = '0;
		m_joy0     = '0;
		m_joy1     = '0;
		m_status   = '0;
		m_req      = '0;
		m_count    = '0;
		wait (rst_n === 1'b1);
		@(posedge clk_sys);
		#1;

		err0 = errors;
		compare_value("io_dout", 0, io_dout);
		compare_value("buttons", 0, buttons);
		compare_value("forced_scandoubler", 0, forced_scandoubler);
		compare_value("direct_video", 0, direct_video);
		compare_value("joystick_0", 0, joystick_0);
		compare_value("joystick_1", 0, joystick_1);
		compare_value("status", 0, status);
		compare_value("ioctl_download", 0, ioctl_download);
		compare_value("ioctl_index", 0, ioctl_index);
		compare_value("ioctl_wr", 0, ioctl_wr);
		compare_value("ioctl_addr", 0, ioctl_addr);
		compare_value("ioctl_dout", 0, ioctl_dout);
		end_test("reset", err0);

		err0 = errors;
		m_cfg = rand_bits(16);
		open_frame(1'b1, 8'h01);
		send_word(m_cfg);
		close_frame();
		compare_value("buttons", m_cfg[1:0], buttons);
		compare_value("forced_scandoubler", m_cfg[4], forced_scandoubler);
		compare_value("direct_video", m_cfg[10], direct_video);
		end_test("config", err0);

		err0 = errors;
		m_joy0 = rand_bits(32);
		open_frame(1'b1, 8'h02);
		send_word(m_joy0[15:0]);
		send_word(m_joy0[31:16]);
		close_frame();
		m_joy1 = rand_bits(32);
		open_frame(1'b1, 8'h03);
		send_word(m_joy1[15:0]);
		send_word(m_joy1[31:16]);
		close_frame();
		// two words past the eighth slice
		open_frame(1'b1, 8'h1E);
		for (int i = 0; i < 10; i++) begin
			w = rand_bits(16);
			if (i < 8)
				m_status[i*16 +: 16] = w;
			send_word(w);
		end
		close_frame();
		compare_value("joystick_0", m_joy0, joystick_0);
		compare_value("joystick_1", m_joy1, joystick_1);
		compare_value("status", m_status, status);
		end_test("joystick and status", err0);

		err0 = errors;
		n = rand_bits(5);
		repeat (n)
			pulse_status({rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)});
		open_frame(1'b1, 8'h29);
		read_reply(rand_bits(16), rd);
		compare_value("io_dout", {8'h00, 4'hA, m_count}, rd);
		for (int i = 0; i < 8; i++) begin
			read_reply(rand_bits(16), rd);
			compare_value("io_dout", m_req[i*16 +: 16], rd);
		end
		close_frame();
		compare_value("io_dout", 0, io_dout);
		end_test("status request", err0);

		err0 = errors;
		w = rand_bits(16);
		open_frame(1'b0, 8'h55);
		send_word(w);
		close_frame();
		compare_value("ioctl_index", w, ioctl_index);
		// bytes before the start frame go nowhere
		wr0 = wr_seen;
		open_frame(1'b0, 8'h54);
		send_word(rand_bits(16));
		send_word(rand_bits(16));
		close_frame();
		compare_value("idle ioctl_wr count", wr0, wr_seen);
		open_frame(1'b0, 8'h53);
		send_word({8'(rand_bits(8)), 7'(rand_bits(7)), 1'b1});
		close_frame();
		compare_value("ioctl_download", 1, ioctl_download);
		n = rand_bits(4) + 1;
		wr0 = wr_seen;
		open_frame(1'b0, 8'h54);
		// back-to-back strobes, one byte per cycle
		@(posedge clk_sys);
		#1;
		for (int i = 0; i < n; i++) begin
			w = rand_bits(16);
			wr_expect.push_back({27'(i), w[7:0]});
			io_strobe = 1'b1;
			io_din    = w;
			@(posedge clk_sys);
			#1;
		end
		io_strobe = 1'b0;
		close_frame();
		open_frame(1'b0, 8'h53);
		send_word({8'(rand_bits(8)), 8'h00});
		close_frame();
		compare_value("ioctl_download", 0, ioctl_download);
		compare_value("ioctl_wr count", n, wr_seen - wr0);
		compare_value("outstanding bytes", 0, wr_expect.size());
		end_test("download", err0);

		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
		if (errors == 0 && failed == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: tests/hps_link_props.sv
// concurrent checks on the host link: enables, ioctl_wr pulse, command word framing
`timescale 1ns/100ps

module hps_link_props (
	input logic clk_sys,
	input logic rst_n,
	input logic io_enable,
	input logic fp_enable,
	input logic io_strobe,
	input logic word_valid,
	input logic ioctl_wr,
	input logic ioctl_download
);

	logic frame_open;
	logic cmd_word;

	// first strobe after an enable rises is the command
	assign cmd_word = io_strobe && (io_enable || fp_enable) && !frame_open;

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			frame_open <= 1'b0;
		else if (!io_enable && !fp_enable)
			frame_open <= 1'b0;
		else if (cmd_word)
			frame_open <= 1'b1;
	end

	//////////////////////////////////////////////////
	a_one_enable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(io_enable && fp_enable))
		else $error("io_enable and fp_enable are high together");

	// a second cycle of ioctl_wr needs a byte of its own
	a_wr_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |=> !ioctl_wr || $past(word_valid))
		else $error("ioctl_wr stayed high with no new byte");

	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl_wr pulsed outside a download");

	a_no_cmd_valid: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmd_word |=> !word_valid)
		else $error("word_valid followed a command word");

endmodule

bind hps_link hps_link_props u_props (
	.clk_sys, .rst_n, .io_enable, .fp_enable, .io_strobe,
	.word_valid, .ioctl_wr, .ioctl_download
);

// File: tests/hps_clock_gen.sv
// testbench clock and synchronous reset source
`timescale 1ns/100ps

module hps_clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	// 8 ns period
	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// low for three rising edges, released just after the third
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1 rst_n = 1'b1;
	end

endmodule

// File: design/hps_link.sv
// top level of the host command link: decode, register, loader and reply blocks
`timescale 1ns/100ps
`include "hps_config.svh"

module hps_link (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          io_enable,
	input  logic                          fp_enable,
	input  logic                          io_strobe,
	input  logic [`HPS_WORD_W-1:0]        io_din,
	input  hps_core_pkg::status_t         status_in,
	input  logic                          status_set,
	output logic [`HPS_WORD_W-1:0]        io_dout,
	output logic [1:0]                    buttons,
	output logic                          forced_scandoubler,
	output logic                          direct_video,
	output hps_core_pkg::joy_t            joystick_0,
	output hps_core_pkg::joy_t            joystick_1,
	output hps_core_pkg::status_t         status,
	output logic                          ioctl_download,
	output logic [`HPS_WORD_W-1:0]        ioctl_index,
	output logic                          ioctl_wr,
	output logic [`HPS_ADDR_W-1:0]        ioctl_addr,
	output logic [`HPS_DL_W-1:0]          ioctl_dout
);

	// decoded data word, shared by all execute blocks
	logic                     word_valid;
	hps_proto_pkg::opcode_t   opcode;
	hps_proto_pkg::word_idx_t word_idx;
	logic [`HPS_WORD_W-1:0]   word_data;
	logic                     uio_active;

	// status request path into the reply block
	hps_core_pkg::status_t    status_req;
	logic [`HPS_REQ_W-1:0]    req_count;

	//////////////////////////////////////////////////
	hps_cmd_decode u_decode (
		.clk_sys, .rst_n, .io_enable, .fp_enable, .io_strobe, .io_din,
		.word_valid, .opcode, .word_idx, .word_data, .uio_active
	);

	hps_core_regs u_regs (
		.clk_sys, .rst_n, .word_valid, .opcode, .word_idx, .word_data,
		.status_in, .status_set, .buttons, .forced_scandoubler, .direct_video,
		.joystick_0, .joystick_1, .status, .status_req, .req_count
	);

	file_loader u_loader (
		.clk_sys, .rst_n, .word_valid, .opcode, .word_data,
		.ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_dout
	);

	hps_readback u_readback (
		.clk_sys, .rst_n, .word_valid, .opcode, .word_idx, .uio_active,
		.status_req, .req_count, .io_dout
	);

endmodule

// File: design/hps_readback.sv
// reply word for the host: status request tag, counter and captured slices
`timescale 1ns/100ps
`include "hps_config.svh"

module hps_readback (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          word_valid,
	input  hps_proto_pkg::opcode_t        opcode,
	input  hps_proto_pkg::word_idx_t      word_idx,
	input  logic                          uio_active,
	input  hps_core_pkg::status_t         status_req,
	input  logic [`HPS_REQ_W-1:0]         req_count,
	output logic [`HPS_WORD_W-1:0]        io_dout
);

	logic [`HPS_WORD_W-1:0]   reply;
	hps_proto_pkg::word_idx_t slice;

	// words 2..9 carry slices 0..7
	assign slice = word_idx - 4'd2;

	always_comb begin
		reply = '0;
		if (opcode == hps_proto_pkg::OP_STREQ) begin
			if (word_idx == 4'd1)
				reply = {8'h00, `HPS_REQ_TAG, req_count};
			else if (word_idx >= 4'd2 && word_idx <= 4'd9)
				reply = status_req[{slice[2:0], 4'b0000} +: 16];
		end
	end

	//////////////////////////////////////////////////
	// reply register, held until the next data word
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			io_dout <= '0;
		else if (!uio_active)
			io_dout <= '0;
		else if (word_valid)
			io_dout <= reply;
	end

endmodule

// File: design/file_loader.sv
// file-I/O download FSM: index, start/stop, byte writes with address counter
`timescale 1ns/100ps
`include "hps_config.svh"

module file_loader (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          word_valid,
	input  hps_proto_pkg::opcode_t        opcode,
	input  logic [`HPS_WORD_W-1:0]        word_data,
	output logic                          ioctl_download,
	output logic [`HPS_WORD_W-1:0]        ioctl_index,
	output logic                          ioctl_wr,
	output logic [`HPS_ADDR_W-1:0]        ioctl_addr,
	output logic [`HPS_DL_W-1:0]          ioctl_dout
);

	hps_core_pkg::loader_state_t state;
	logic [`HPS_ADDR_W-1:0]      next_addr;

	assign ioctl_download = (state == hps_core_pkg::FL_DOWNLOAD);

	//////////////////////////////////////////////////
	// download FSM
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state       <= hps_core_pkg::FL_IDLE;
			ioctl_index <= '0;
			ioctl_wr    <= 1'b0;
			ioctl_addr  <= '0;
			ioctl_dout  <= '0;
			next_addr   <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (word_valid) begin
				case (opcode)
					hps_proto_pkg::OP_FILE_INDEX: ioctl_index <= word_data;
					hps_proto_pkg::OP_FILE_TX: begin
						// nonzero low byte starts, zero stops
						if (word_data[7:0] != 8'h00) begin
							state     <= hps_core_pkg::FL_DOWNLOAD;
							next_addr <= '0;
						end else begin
							state <= hps_core_pkg::FL_IDLE;
						end
					end
					hps_proto_pkg::OP_FILE_DAT: begin
						// bytes outside a download are dropped
						if (state == hps_core_pkg::FL_DOWNLOAD) begin
							ioctl_dout <= word_data[`HPS_DL_W-1:0];
							ioctl_addr <= next_addr;
							ioctl_wr   <= 1'b1;
							next_addr  <= next_addr + 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: design/hps_core_regs.sv
// user-I/O register writes: config, joysticks, status; status request capture
`timescale 1ns/100ps
`include "hps_config.svh"

module hps_core_regs (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          word_valid,
	input  hps_proto_pkg::opcode_t        opcode,
	input  hps_proto_pkg::word_idx_t      word_idx,
	input  logic [`HPS_WORD_W-1:0]        word_data,
	input  hps_core_pkg::status_t         status_in,
	input  logic                          status_set,
	output logic [1:0]                    buttons,
	output logic                          forced_scandoubler,
	output logic                          direct_video,
	output hps_core_pkg::joy_t            joystick_0,
	output hps_core_pkg::joy_t            joystick_1,
	output hps_core_pkg::status_t         status,
	output hps_core_pkg::status_t         status_req,
	output logic [`HPS_REQ_W-1:0]         req_count
);

	logic [`HPS_WORD_W-1:0]   cfg;
	logic                     status_set_d;
	hps_proto_pkg::word_idx_t slice;

	// cfg bits the core sees, the rest belong to the system top
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	// status word k lands in slice k-1
	assign slice = word_idx - 1'b1;

	//////////////////////////////////////////////////
	// host writes
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (word_valid) begin
			case (opcode)
				hps_proto_pkg::OP_CFG: cfg <= word_data;
				hps_proto_pkg::OP_JOY0: begin
					if (word_idx == 4'd1)
						joystick_0[15:0] <= word_data;
					else if (word_idx == 4'd2)
						joystick_0[31:16] <= word_data;
				end
				hps_proto_pkg::OP_JOY1: begin
					if (word_idx == 4'd1)
						joystick_1[15:0] <= word_data;
					else if (word_idx == 4'd2)
						joystick_1[31:16] <= word_data;
				end
				hps_proto_pkg::OP_STATUS: begin
					// eight slices, anything past word 8 is dropped
					if (word_idx >= 4'd1 && word_idx <= 4'd8)
						status[{slice[2:0], 4'b0000} +: 16] <= word_data;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// status request from the core
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_set_d <= 1'b0;
			status_req   <= '0;
			req_count    <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				status_req <= status_in;
				// wraps, host compares against its last value
				req_count  <= req_count + 1'b1;
			end
		end
	end

endmodule

// File: design/hps_cmd_decode.sv
// host word framing: channel tracking, command decode, data word counter
`timescale 1ns/100ps
`include "hps_config.svh"

module hps_cmd_decode (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          io_enable,
	input  logic                          fp_enable,
	input  logic                          io_strobe,
	input  logic [`HPS_WORD_W-1:0]        io_din,
	output logic                          word_valid,
	output hps_proto_pkg::opcode_t        opcode,
	output hps_proto_pkg::word_idx_t      word_idx,
	output logic [`HPS_WORD_W-1:0]        word_data,
	output logic                          uio_active
);

	hps_proto_pkg::chan_t chan;
	hps_proto_pkg::chan_t new_ch;

	// each opcode is only valid on its own channel
	function automatic hps_proto_pkg::opcode_t map_cmd(
		input logic [`HPS_WORD_W-1:0] word,
		input hps_proto_pkg::chan_t   ch
	);
		hps_proto_pkg::opcode_t op;
		op = hps_proto_pkg::OP_NONE;
		if (word[`HPS_WORD_W-1:8] == '0) begin
			if (ch == hps_proto_pkg::CH_UIO) begin
				case (word[7:0])
					8'h01:   op = hps_proto_pkg::OP_CFG;
					8'h02:   op = hps_proto_pkg::OP_JOY0;
					8'h03:   op = hps_proto_pkg::OP_JOY1;
					8'h1E:   op = hps_proto_pkg::OP_STATUS;
					8'h29:   op = hps_proto_pkg::OP_STREQ;
					default: op = hps_proto_pkg::OP_NONE;
				endcase
			end else if (ch == hps_proto_pkg::CH_FIO) begin
				case (word[7:0])
					8'h53:   op = hps_proto_pkg::OP_FILE_TX;
					8'h54:   op = hps_proto_pkg::OP_FILE_DAT;
					8'h55:   op = hps_proto_pkg::OP_FILE_INDEX;
					default: op = hps_proto_pkg::OP_NONE;
				endcase
			end
		end
		return op;
	endfunction

	// host never raises both enables
	always_comb begin
		if (io_enable)
			new_ch = hps_proto_pkg::CH_UIO;
		else if (fp_enable)
			new_ch = hps_proto_pkg::CH_FIO;
		else
			new_ch = hps_proto_pkg::CH_NONE;
	end

	//////////////////////////////////////////////////
	// frame tracking
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			chan       <= hps_proto_pkg::CH_NONE;
			opcode     <= hps_proto_pkg::OP_NONE;
			word_idx   <= '0;
			word_valid <= 1'b0;
			uio_active <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			if (new_ch == hps_proto_pkg::CH_NONE) begin
				// enable dropped, frame is over
				chan       <= hps_proto_pkg::CH_NONE;
				opcode     <= hps_proto_pkg::OP_NONE;
				word_idx   <= '0;
				uio_active <= 1'b0;
			end else if (io_strobe) begin
				if (chan == hps_proto_pkg::CH_NONE) begin
					// command word opens the frame
					chan       <= new_ch;
					opcode     <= map_cmd(io_din, new_ch);
					word_idx   <= '0;
					uio_active <= (new_ch == hps_proto_pkg::CH_UIO);
				end else begin
					word_valid <= 1'b1;
					if (word_idx != '1)
						word_idx <= word_idx + 1'b1;
				end
			end
		end
	end

	// data payload, qualified by word_valid
	always_ff @(posedge clk_sys) begin
		if (io_strobe && chan != hps_proto_pkg::CH_NONE)
			word_data <= io_din;
	end

endmodule

// File: design/hps_core_pkg.sv
// core-facing types: status word, joystick word, loader state
`include "hps_config.svh"

package hps_core_pkg;

	// full status word, written by the host in 16-bit slices
	typedef logic [`HPS_STATUS_W-1:0] status_t;

	// joystick buttons, low half on word 1, high half on word 2
	typedef logic [`HPS_JOY_W-1:0] joy_t;

	//////////////////////////////////////////////////
	// file loader FSM
	typedef enum logic {
		FL_IDLE     = 1'b0,
		FL_DOWNLOAD = 1'b1
	} loader_state_t;

endpackage

// File: design/hps_proto_pkg.sv
// host protocol types: channel, command opcode, data word index
`include "hps_config.svh"

package hps_proto_pkg;

	// which enable opened the current frame
	typedef enum logic [1:0] {
		CH_NONE = 2'd0,
		CH_UIO  = 2'd1,
		CH_FIO  = 2'd2
	} chan_t;

	//////////////////////////////////////////////////
	// command word values, user-I/O then file-I/O
	typedef enum logic [7:0] {
		OP_NONE       = 8'h00,
		OP_CFG        = 8'h01,
		OP_JOY0       = 8'h02,
		OP_JOY1       = 8'h03,
		OP_STATUS     = 8'h1E,
		OP_STREQ      = 8'h29,
		OP_FILE_TX    = 8'h53,
		OP_FILE_DAT   = 8'h54,
		OP_FILE_INDEX = 8'h55
	} opcode_t;

	// 1 for the first data word, sticks at 15
	typedef logic [`HPS_IDX_W-1:0] word_idx_t;

endpackage

// File: design/hps_config.svh
// link widths, counts and the status-request reply tag
`ifndef HPS_CONFIG_SVH
`define HPS_CONFIG_SVH

// host bus word
`define HPS_WORD_W 16

// core-facing words
`define HPS_STATUS_W 128
`define HPS_JOY_W 32

// file download
`define HPS_ADDR_W 27
`define HPS_DL_W 8

// frame word counter and status request counter
`define HPS_IDX_W 4
`define HPS_REQ_W 4
`define HPS_REQ_TAG 4'hA

`endif
